// File: hdl/alu.sv
/*
  Integer ALU
  Add/sub, signed and unsigned compares, logic and shifts,
  plus an optional signed multiply giving the low or high word.
*/
`timescale 1ns/1ps

module alu #(
  parameter int ENABLE_M_EXT = 0
) (
  input  logic [ex_pkg::XLEN-1:0] op1_i,
  input  logic [ex_pkg::XLEN-1:0] op2_i,
  input  ex_pkg::alu_op_t         alu_op_i,
  output logic [ex_pkg::XLEN-1:0] res_o
);
  import ex_pkg::*;

  logic [SHAMT_W-1:0]       shamt;
  logic signed [2*XLEN-1:0] prod;
  logic                     lt_s;
  logic                     lt_u;

  assign shamt = op2_i[SHAMT_W-1:0];
  assign lt_s  = $signed(op1_i) < $signed(op2_i);
  assign lt_u  = op1_i < op2_i;

  generate
    if (ENABLE_M_EXT != 0) begin : g_mul
      assign prod = $signed(op1_i) * $signed(op2_i);
    end
    else begin : g_no_mul
      // Without M, both multiply ops read back zero
      assign prod = '0;
    end
  endgenerate

  always_comb begin
    case (alu_op_i)
      ALU_ADD:  res_o = op1_i + op2_i;
      ALU_SUB:  res_o = op1_i - op2_i;
      ALU_SLT:  res_o = {{(XLEN-1){1'b0}}, lt_s};
      ALU_SLTU: res_o = {{(XLEN-1){1'b0}}, lt_u};
      ALU_XOR:  res_o = op1_i ^ op2_i;
      ALU_OR:   res_o = op1_i | op2_i;
      ALU_AND:  res_o = op1_i & op2_i;
      ALU_SLL:  res_o = op1_i << shamt;
      ALU_SRL:  res_o = op1_i >> shamt;
      ALU_SRA:  res_o = $signed(op1_i) >>> shamt;
      ALU_MUL:  res_o = prod[XLEN-1:0];
      ALU_MULH: res_o = prod[2*XLEN-1:XLEN];
      default:  res_o = '0;
    endcase
  end

endmodule

// File: hdl/branch_unit.sv
/*
  Branch unit
  Evaluates the RV branch conditions and forms the redirect
  target for a taken branch or a jump.
*/
`timescale 1ns/1ps

module branch_unit (
  input  logic [ex_pkg::XLEN-1:0] op1_i,
  input  logic [ex_pkg::XLEN-1:0] op2_i,
  input  ex_pkg::br_op_t          br_op_i,
  input  logic                    branch_i,
  input  logic                    jump_i,
  input  logic [ex_pkg::XLEN-1:0] pc_i,
  input  logic [ex_pkg::XLEN-1:0] imm_i,
  input  logic [ex_pkg::XLEN-1:0] alu_res_i,
  output logic                    take_o,
  output logic [ex_pkg::XLEN-1:0] target_o
);
  import ex_pkg::*;

  logic cond;

  always_comb begin
    case (br_op_i)
      BR_EQ:   cond = (op1_i == op2_i);
      BR_NE:   cond = (op1_i != op2_i);
      BR_LT:   cond = ($signed(op1_i) < $signed(op2_i));
      BR_GE:   cond = ($signed(op1_i) >= $signed(op2_i));
      BR_LTU:  cond = (op1_i < op2_i);
      BR_GEU:  cond = (op1_i >= op2_i);
      default: cond = 1'b0;
    endcase
  end

  assign take_o = (branch_i && cond) || jump_i;

  // JAL and JALR both clear bit 0 of the computed sum
  assign target_o = jump_i ? {alu_res_i[XLEN-1:1], 1'b0} : (pc_i + imm_i);

  always_comb begin
    if (!$isunknown({branch_i, jump_i})) begin
      a_br_jmp_excl: assert final (!(branch_i && jump_i));
    end
  end

endmodule

// File: hdl/ex_pkg.sv
/*
  Execute stage shared definitions
  Datapath widths, operand sources, ALU and branch opcodes
  and the PC constants used by the RV32 execute stage.
*/
package ex_pkg;

  localparam int XLEN    = 32;
  localparam int RADDR_W = 5;
  localparam int SHAMT_W = $clog2(XLEN);

  // Instruction size and link offset of a jump
  localparam logic [XLEN-1:0] PC_STEP  = 'd4;
  localparam logic [XLEN-1:0] RESET_PC = 'h0;

  typedef enum logic [1:0] {
    SRC_REG,
    SRC_IMM,
    SRC_ZERO,
    SRC_PC
  } src_sel_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_OR,
    ALU_AND,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_MUL,
    ALU_MULH
  } alu_op_t;

  // Same values as the branch funct3 field
  typedef enum logic [2:0] {
    BR_EQ  = 3'b000,
    BR_NE  = 3'b001,
    BR_LT  = 3'b100,
    BR_GE  = 3'b101,
    BR_LTU = 3'b110,
    BR_GEU = 3'b111
  } br_op_t;

endpackage

// File: hdl/ex_result_reg.sv
/*
  Execute result register
  Holds the stage output, stalls on load/store back-pressure,
  squashes the instruction behind a redirect and raises a
  one-cycle fetch request for taken branches and jumps.
*/
`timescale 1ns/1ps

module ex_result_reg (
  input  logic                       clk,
  input  logic                       rst_n_i,
  input  logic                       id_valid_i,
  input  logic                       lsu_bp_i,
  input  logic [ex_pkg::XLEN-1:0]    alu_res_i,
  input  logic [ex_pkg::XLEN-1:0]    pc_i,
  input  logic                       jump_i,
  input  logic [ex_pkg::RADDR_W-1:0] rd_addr_i,
  input  logic                       we_rd_i,
  input  logic                       take_i,
  input  logic [ex_pkg::XLEN-1:0]    target_i,
  output logic                       id_ready_o,
  output logic [ex_pkg::XLEN-1:0]    ex_result_o,
  output logic [ex_pkg::RADDR_W-1:0] ex_rd_addr_o,
  output logic                       ex_we_rd_o,
  output logic                       ex_valid_o,
  output logic                       fetch_req_o,
  output logic [ex_pkg::XLEN-1:0]    fetch_addr_o
);
  import ex_pkg::*;

  logic accept;
  logic load;

  assign id_ready_o = ~lsu_bp_i;
  assign accept     = id_valid_i && id_ready_o;
  // Instruction behind a redirect is dropped
  assign load       = accept && ~fetch_req_o;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      ex_result_o  <= '0;
      ex_rd_addr_o <= '0;
      ex_we_rd_o   <= 1'b0;
      ex_valid_o   <= 1'b0;
      fetch_req_o  <= 1'b0;
      fetch_addr_o <= RESET_PC;
    end
    else if (lsu_bp_i) begin
      fetch_req_o <= 1'b0;
    end
    else begin
      ex_valid_o  <= load;
      ex_we_rd_o  <= load && we_rd_i;
      fetch_req_o <= load && take_i;
      if (load) begin
        ex_result_o  <= jump_i ? (pc_i + PC_STEP) : alu_res_i;
        ex_rd_addr_o <= rd_addr_i;
      end
      if (load && take_i) begin
        fetch_addr_o <= target_i;
      end
    end
  end

  a_redirect_one_cycle: assert property (@(posedge clk) disable iff (!rst_n_i)
    fetch_req_o |=> !fetch_req_o);

  a_hold_on_bp: assert property (@(posedge clk) disable iff (!rst_n_i)
    lsu_bp_i |=> $stable(ex_result_o));

endmodule

// File: hdl/execute_stage.sv
/*
  RV32 execute stage
  Operand select, ALU with multiply, branch unit and the
  result register, joined into one pipeline stage.
*/
`timescale 1ns/1ps

module execute_stage (
  input  logic                       clk,
  input  logic                       rst_n_i,
  input  logic                       lsu_bp_i,
  input  logic                       id_valid_i,
  input  ex_pkg::src_sel_t           rs1_sel_i,
  input  ex_pkg::src_sel_t           rs2_sel_i,
  input  logic [ex_pkg::RADDR_W-1:0] rs1_addr_i,
  input  logic [ex_pkg::RADDR_W-1:0] rs2_addr_i,
  input  logic [ex_pkg::XLEN-1:0]    rs1_data_i,
  input  logic [ex_pkg::XLEN-1:0]    rs2_data_i,
  input  logic [ex_pkg::XLEN-1:0]    imm_i,
  input  logic [ex_pkg::XLEN-1:0]    pc_i,
  input  ex_pkg::alu_op_t            alu_op_i,
  input  ex_pkg::br_op_t             br_op_i,
  input  logic                       branch_i,
  input  logic                       jump_i,
  input  logic [ex_pkg::RADDR_W-1:0] rd_addr_i,
  input  logic                       we_rd_i,
  output logic                       id_ready_o,
  output logic [ex_pkg::XLEN-1:0]    ex_result_o,
  output logic [ex_pkg::RADDR_W-1:0] ex_rd_addr_o,
  output logic                       ex_we_rd_o,
  output logic                       ex_valid_o,
  output logic                       fetch_req_o,
  output logic [ex_pkg::XLEN-1:0]    fetch_addr_o
);
  import ex_pkg::*;

  logic [XLEN-1:0] op1;
  logic [XLEN-1:0] op2;
  logic [XLEN-1:0] alu_res;
  logic [XLEN-1:0] target;
  logic            take;

  operand_select u_operand_select (
    .rs1_sel_i  (rs1_sel_i),
    .rs2_sel_i  (rs2_sel_i),
    .rs1_addr_i (rs1_addr_i),
    .rs2_addr_i (rs2_addr_i),
    .rs1_data_i (rs1_data_i),
    .rs2_data_i (rs2_data_i),
    .imm_i      (imm_i),
    .pc_i       (pc_i),
    .fwd_data_i (ex_result_o),
    .fwd_rd_i   (ex_rd_addr_o),
    .fwd_we_i   (ex_we_rd_o),
    .op1_o      (op1),
    .op2_o      (op2)
  );

  alu #(
    .ENABLE_M_EXT (1)
  ) u_alu (
    .op1_i    (op1),
    .op2_i    (op2),
    .alu_op_i (alu_op_i),
    .res_o    (alu_res)
  );

  branch_unit u_branch_unit (
    .op1_i     (op1),
    .op2_i     (op2),
    .br_op_i   (br_op_i),
    .branch_i  (branch_i),
    .jump_i    (jump_i),
    .pc_i      (pc_i),
    .imm_i     (imm_i),
    .alu_res_i (alu_res),
    .take_o    (take),
    .target_o  (target)
  );

  ex_result_reg u_ex_result_reg (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .id_valid_i   (id_valid_i),
    .lsu_bp_i     (lsu_bp_i),
    .alu_res_i    (alu_res),
    .pc_i         (pc_i),
    .jump_i       (jump_i),
    .rd_addr_i    (rd_addr_i),
    .we_rd_i      (we_rd_i),
    .take_i       (take),
    .target_i     (target),
    .id_ready_o   (id_ready_o),
    .ex_result_o  (ex_result_o),
    .ex_rd_addr_o (ex_rd_addr_o),
    .ex_we_rd_o   (ex_we_rd_o),
    .ex_valid_o   (ex_valid_o),
    .fetch_req_o  (fetch_req_o),
    .fetch_addr_o (fetch_addr_o)
  );

endmodule

// File: hdl/operand_select.sv
/*
  Operand select
  Picks each ALU operand from the register file, the immediate,
  zero or the PC, then forwards the registered execute result
  when it targets the same register.
*/
`timescale 1ns/1ps

module operand_select (
  input  ex_pkg::src_sel_t           rs1_sel_i,
  input  ex_pkg::src_sel_t           rs2_sel_i,
  input  logic [ex_pkg::RADDR_W-1:0] rs1_addr_i,
  input  logic [ex_pkg::RADDR_W-1:0] rs2_addr_i,
  input  logic [ex_pkg::XLEN-1:0]    rs1_data_i,
  input  logic [ex_pkg::XLEN-1:0]    rs2_data_i,
  input  logic [ex_pkg::XLEN-1:0]    imm_i,
  input  logic [ex_pkg::XLEN-1:0]    pc_i,
  input  logic [ex_pkg::XLEN-1:0]    fwd_data_i,
  input  logic [ex_pkg::RADDR_W-1:0] fwd_rd_i,
  input  logic                       fwd_we_i,
  output logic [ex_pkg::XLEN-1:0]    op1_o,
  output logic [ex_pkg::XLEN-1:0]    op2_o
);
  import ex_pkg::*;

  function automatic logic [XLEN-1:0] pick_op(
    src_sel_t            sel,
    logic [RADDR_W-1:0]  addr,
    logic [XLEN-1:0]     rdata,
    logic [XLEN-1:0]     imm,
    logic [XLEN-1:0]     pc,
    logic [XLEN-1:0]     fwd_data,
    logic [RADDR_W-1:0]  fwd_rd,
    logic                fwd_we
  );
    logic [XLEN-1:0] op;
    case (sel)
      SRC_REG:  op = rdata;
      SRC_IMM:  op = imm;
      SRC_PC:   op = pc;
      default:  op = '0;
    endcase
    // Bypass from the result register except for x0
    if ((sel == SRC_REG) && fwd_we && (fwd_rd != '0) && (fwd_rd == addr)) begin
      op = fwd_data;
    end
    return op;
  endfunction

  always_comb begin
    op1_o = pick_op(rs1_sel_i, rs1_addr_i, rs1_data_i, imm_i, pc_i,
                    fwd_data_i, fwd_rd_i, fwd_we_i);
    op2_o = pick_op(rs2_sel_i, rs2_addr_i, rs2_data_i, imm_i, pc_i,
                    fwd_data_i, fwd_rd_i, fwd_we_i);
  end

  // A read of x0 always sees the register file value
  always_comb begin
    if ((rs1_sel_i == SRC_REG) && (rs1_addr_i == '0)) begin
      a_no_fwd_x0_rs1: assert final (op1_o == rs1_data_i);
    end
    if ((rs2_sel_i == SRC_REG) && (rs2_addr_i == '0)) begin
      a_no_fwd_x0_rs2: assert final (op2_o == rs2_data_i);
    end
  end

endmodule

// File: project.f
hdl/ex_pkg.sv
hdl/operand_select.sv
hdl/alu.sv
hdl/branch_unit.sv
hdl/ex_result_reg.sv
hdl/execute_stage.sv
testbench/clk_gen.sv
testbench/tb_execute.sv

// File: testbench/clk_gen.sv
/*
  Testbench clock and reset
  Free-running clock and an active-low reset held for a fixed
  number of cycles after start.
*/
`timescale 1ns/1ps

module clk_gen #(
  parameter int PERIOD_NS  = 100,
  parameter int RST_CYCLES = 10
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

// File: testbench/tb_execute.sv
/*
  Execute stage testbench
  Directed tests for the ALU ops and operand sources, result
  forwarding, branches, jumps with squash, load/store
  back-pressure and reset.
*/
`timescale 1ns/1ps

module tb_execute;
  import ex_pkg::*;

  localparam int CLK_PERIOD_NS = 100;
  localparam int RST_CYCLES    = 10;
  // ALU, forwarding, branch, jump, back-pressure and reset groups
  localparam int TEST_CYCLES   = 12*4*2 + 5*3 + 6*3*3 + 2*4 + 12 + 2;
  localparam int MARGIN_CYCLES = 100;
  localparam int WATCHDOG_NS   = (RST_CYCLES + TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD_NS;

  logic               clk;
  logic               rst_n_i;
  logic               lsu_bp_i;
  logic               id_valid_i;
  src_sel_t           rs1_sel_i;
  src_sel_t           rs2_sel_i;
  logic [RADDR_W-1:0] rs1_addr_i;
  logic [RADDR_W-1:0] rs2_addr_i;
  logic [XLEN-1:0]    rs1_data_i;
  logic [XLEN-1:0]    rs2_data_i;
  logic [XLEN-1:0]    imm_i;
  logic [XLEN-1:0]    pc_i;
  alu_op_t            alu_op_i;
  br_op_t             br_op_i;
  logic               branch_i;
  logic               jump_i;
  logic [RADDR_W-1:0] rd_addr_i;
  logic               we_rd_i;
  logic               id_ready_o;
  logic [XLEN-1:0]    ex_result_o;
  logic [RADDR_W-1:0] ex_rd_addr_o;
  logic               ex_we_rd_o;
  logic               ex_valid_o;
  logic               fetch_req_o;
  logic [XLEN-1:0]    fetch_addr_o;
  integer             seed;

  clk_gen #(
    .PERIOD_NS  (CLK_PERIOD_NS),
    .RST_CYCLES (RST_CYCLES)
  ) u_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n_i)
  );

  execute_stage DUT (.*);

  task automatic check_val(input string name, input logic [XLEN-1:0] exp,
                           input logic [XLEN-1:0] act);
    if (act !== exp) begin
      $display("FAILED %s: expected %h, actual %h", name, exp, act);
      $display("Checks failed");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  function automatic logic [XLEN-1:0] model_src(src_sel_t sel, logic [XLEN-1:0] reg_val,
                                                logic [XLEN-1:0] imm, logic [XLEN-1:0] pc);
    if (sel == SRC_IMM) return imm;
    if (sel == SRC_PC) return pc;
    if (sel == SRC_ZERO) return '0;
    return reg_val;
  endfunction

  function automatic logic [XLEN-1:0] model_alu(alu_op_t op, logic [XLEN-1:0] a,
                                                logic [XLEN-1:0] b);
    logic signed [63:0] prod;
    logic [63:0]        ext;
    logic               lt_s;
    prod = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
    // Sign-extended right shift gives SRA in the low word
    ext  = {{32{a[31]}}, a} >> b[4:0];
    lt_s = (a[31] != b[31]) ? a[31] : (a < b);
    case (op)
      ALU_ADD:  return a + b;
      ALU_SUB:  return a + ~b + 32'd1;
      ALU_SLT:  return {31'b0, lt_s};
      ALU_SLTU: return {31'b0, a < b};
      ALU_XOR:  return a ^ b;
      ALU_OR:   return a | b;
      ALU_AND:  return a & b;
      ALU_SLL:  return a << b[4:0];
      ALU_SRL:  return a >> b[4:0];
      ALU_SRA:  return ext[31:0];
      ALU_MUL:  return prod[31:0];
      ALU_MULH: return prod[63:32];
      default:  return '0;
    endcase
  endfunction

  function automatic logic model_branch(br_op_t op, logic [XLEN-1:0] a, logic [XLEN-1:0] b);
    logic lt_s;
    lt_s = (a[31] != b[31]) ? a[31] : (a < b);
    case (op)
      BR_EQ:   return a == b;
      BR_NE:   return a != b;
      BR_LT:   return lt_s;
      BR_GE:   return !lt_s;
      BR_LTU:  return a < b;
      BR_GEU:  return !(a < b);
      default: return 1'b0;
    endcase
  endfunction

  task automatic drive_instr(
    input src_sel_t s1, input src_sel_t s2,
    input logic [RADDR_W-1:0] a1, input logic [RADDR_W-1:0] a2,
    input logic [XLEN-1:0] d1, input logic [XLEN-1:0] d2,
    input logic [XLEN-1:0] imm, input logic [XLEN-1:0] pc,
    input alu_op_t op, input br_op_t bop, input logic br, input logic jmp,
    input logic [RADDR_W-1:0] rd, input logic we);
    id_valid_i <= 1'b1;
    rs1_sel_i  <= s1;
    rs2_sel_i  <= s2;
    rs1_addr_i <= a1;
    rs2_addr_i <= a2;
    rs1_data_i <= d1;
    rs2_data_i <= d2;
    imm_i      <= imm;
    pc_i       <= pc;
    alu_op_i   <= op;
    br_op_i    <= bop;
    branch_i   <= br;
    jump_i     <= jmp;
    rd_addr_i  <= rd;
    we_rd_i    <= we;
  endtask

  // Returns on the edge that accepts the driven instruction
  task automatic wait_accept();
    @(posedge clk);
    while (!id_ready_o) begin
      @(posedge clk);
    end
  endtask

  task automatic bubble();
    id_valid_i <= 1'b0;
    branch_i   <= 1'b0;
    jump_i     <= 1'b0;
    we_rd_i    <= 1'b0;
  endtask

  task automatic test_reset();
    check_val("reset valid", 1'b0, ex_valid_o);
    check_val("reset we", 1'b0, ex_we_rd_o);
    check_val("reset fetch_req", 1'b0, fetch_req_o);
    check_val("reset result", '0, ex_result_o);
  endtask

  task automatic test_alu();
    src_sel_t           s1 [4];
    src_sel_t           s2 [4];
    alu_op_t            op;
    logic [XLEN-1:0]    a;
    logic [XLEN-1:0]    b;
    logic [XLEN-1:0]    imm;
    logic [XLEN-1:0]    pc;
    logic [RADDR_W-1:0] rd;
    logic [XLEN-1:0]    exp;
    string              name;
    s1 = '{SRC_REG, SRC_REG, SRC_PC, SRC_ZERO};
    s2 = '{SRC_REG, SRC_IMM, SRC_IMM, SRC_REG};
    for (int i = 0; i < 12; i++) begin
      for (int v = 0; v < 4; v++) begin
        op   = alu_op_t'(i);
        a    = $random(seed);
        b    = $random(seed);
        imm  = $random(seed);
        pc   = $random(seed) & 32'hffff_fffc;
        rd   = RADDR_W'(i + 1);
        exp  = model_alu(op, model_src(s1[v], a, imm, pc), model_src(s2[v], b, imm, pc));
        name = $sformatf("alu op %0d src %0d", i, v);
        @(posedge clk);
        drive_instr(s1[v], s2[v], 5'd1, 5'd2, a, b, imm, pc, op, BR_EQ, 1'b0, 1'b0, rd, 1'b1);
        wait_accept();
        bubble();
        @(negedge clk);
        check_val(name, exp, ex_result_o);
        check_val(name, 1'b1, ex_valid_o);
        check_val(name, rd, ex_rd_addr_o);
      end
    end
  endtask

  task automatic fwd_pair(input string name, input logic [RADDR_W-1:0] rd, input logic we,
                          input logic hit1, input logic hit2);
    logic [XLEN-1:0]    a;
    logic [XLEN-1:0]    b;
    logic [XLEN-1:0]    c;
    logic [XLEN-1:0]    d;
    logic [XLEN-1:0]    first;
    logic [XLEN-1:0]    op1;
    logic [XLEN-1:0]    op2;
    logic [RADDR_W-1:0] a1;
    logic [RADDR_W-1:0] a2;
    a     = $random(seed);
    b     = $random(seed);
    c     = $random(seed);
    d     = $random(seed);
    a1    = hit1 ? rd : (rd ^ 5'h10);
    a2    = hit2 ? rd : (rd ^ 5'h11);
    first = a + b;
    op1   = (hit1 && we && (rd != 0)) ? first : c;
    op2   = (hit2 && we && (rd != 0)) ? first : d;
    @(posedge clk);
    drive_instr(SRC_REG, SRC_REG, 5'd3, 5'd4, a, b, '0, '0, ALU_ADD, BR_EQ,
                1'b0, 1'b0, rd, we);
    wait_accept();
    drive_instr(SRC_REG, SRC_REG, a1, a2, c, d, '0, '0, ALU_ADD, BR_EQ,
                1'b0, 1'b0, 5'd20, 1'b1);
    wait_accept();
    bubble();
    @(negedge clk);
    check_val(name, op1 + op2, ex_result_o);
  endtask

  task automatic test_branch();
    br_op_t          ops [6];
    logic [XLEN-1:0] lhs [3];
    logic [XLEN-1:0] rhs [3];
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] imm;
    logic            exp_take;
    string           name;
    ops = '{BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU};
    // Equal, less, and negative against positive
    lhs = '{32'd5, 32'd5, 32'hffff_ffff};
    rhs = '{32'd5, 32'd6, 32'd1};
    for (int i = 0; i < 6; i++) begin
      for (int k = 0; k < 3; k++) begin
        pc       = $random(seed) & 32'hffff_fffc;
        imm      = $random(seed) & 32'h0000_0ffc;
        exp_take = model_branch(ops[i], lhs[k], rhs[k]);
        name     = $sformatf("branch op %0d pair %0d", i, k);
        @(posedge clk);
        drive_instr(SRC_REG, SRC_REG, 5'd1, 5'd2, lhs[k], rhs[k], imm, pc, ALU_SUB, ops[i],
                    1'b1, 1'b0, 5'd0, 1'b0);
        wait_accept();
        bubble();
        @(negedge clk);
        check_val(name, exp_take, fetch_req_o);
        if (exp_take) begin
          check_val(name, pc + imm, fetch_addr_o);
        end
        check_val(name, 1'b0, ex_we_rd_o);
        @(negedge clk);
        check_val(name, 1'b0, fetch_req_o);
      end
    end
  endtask

  task automatic jump_case(input string name, input src_sel_t s1, input logic [XLEN-1:0] base);
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] target;
    pc     = $random(seed) & 32'hffff_fffc;
    // Odd offset so that bit 0 of the sum must be cleared
    imm    = $random(seed) | 32'h1;
    target = (model_src(s1, base, imm, pc) + imm) & ~32'h1;
    @(posedge clk);
    drive_instr(s1, SRC_IMM, 5'd1, 5'd0, base, '0, imm, pc, ALU_ADD, BR_EQ,
                1'b0, 1'b1, 5'd1, 1'b1);
    wait_accept();
    // Taken branch with a write right behind the jump
    drive_instr(SRC_REG, SRC_REG, 5'd2, 5'd3, 32'd7, 32'd7, 32'h100, pc + 32'd4, ALU_ADD,
                BR_EQ, 1'b1, 1'b0, 5'd9, 1'b1);
    @(negedge clk);
    check_val(name, pc + 32'd4, ex_result_o);
    check_val(name, 1'b1, fetch_req_o);
    check_val(name, target, fetch_addr_o);
    check_val(name, 1'b1, ex_we_rd_o);
    wait_accept();
    bubble();
    @(negedge clk);
    check_val(name, 1'b0, ex_valid_o);
    check_val(name, 1'b0, ex_we_rd_o);
    check_val(name, 1'b0, fetch_req_o);
    check_val(name, pc + 32'd4, ex_result_o);
    @(negedge clk);
    check_val(name, 1'b0, fetch_req_o);
  endtask

  task automatic test_backpressure();
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] c;
    logic [XLEN-1:0] d;
    a = $random(seed);
    b = $random(seed);
    c = $random(seed);
    d = $random(seed);
    @(posedge clk);
    drive_instr(SRC_REG, SRC_REG, 5'd1, 5'd2, a, b, '0, '0, ALU_ADD, BR_EQ,
                1'b0, 1'b0, 5'd10, 1'b1);
    wait_accept();
    bubble();
    @(negedge clk);
    check_val("bp first", a + b, ex_result_o);
    @(posedge clk);
    lsu_bp_i <= 1'b1;
    drive_instr(SRC_REG, SRC_REG, 5'd3, 5'd4, c, d, '0, '0, ALU_SUB, BR_EQ,
                1'b0, 1'b0, 5'd11, 1'b1);
    repeat (4) begin
      @(negedge clk);
      check_val("bp ready", 1'b0, id_ready_o);
      check_val("bp hold", a + b, ex_result_o);
    end
    @(posedge clk);
    lsu_bp_i <= 1'b0;
    wait_accept();
    bubble();
    @(negedge clk);
    check_val("bp release", c - d, ex_result_o);
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired: tests did not finish within %0d ns", WATCHDOG_NS);
    $display("Checks failed");
    $fatal(1, "Simulation stopped by the watchdog");
  end

  initial begin
    seed       = 32'h56a24524;
    lsu_bp_i   <= 1'b0;
    rs1_sel_i  <= SRC_REG;
    rs2_sel_i  <= SRC_REG;
    rs1_addr_i <= '0;
    rs2_addr_i <= '0;
    rs1_data_i <= '0;
    rs2_data_i <= '0;
    imm_i      <= '0;
    pc_i       <= '0;
    alu_op_i   <= ALU_ADD;
    br_op_i    <= BR_EQ;
    rd_addr_i  <= '0;
    bubble();
    wait (rst_n_i === 1'b1);
    @(negedge clk);
    test_reset();
    test_alu();
    fwd_pair("fwd rs1", 5'd5, 1'b1, 1'b1, 1'b0);
    fwd_pair("fwd rs2", 5'd5, 1'b1, 1'b0, 1'b1);
    fwd_pair("fwd both", 5'd5, 1'b1, 1'b1, 1'b1);
    fwd_pair("no fwd x0", 5'd0, 1'b1, 1'b1, 1'b1);
    fwd_pair("no fwd we low", 5'd6, 1'b0, 1'b1, 1'b1);
    test_branch();
    jump_case("jal", SRC_PC, '0);
    jump_case("jalr", SRC_REG, $random(seed));
    test_backpressure();
    $display("All checks passed");
    $finish;
  end

endmodule
